//--- hdl/uart_pkg.sv
package uart_pkg;

    // bit time in clk cycles, needs at least 2
    localparam int CLKS_PER_BAUD = 8;

    localparam int BAUD_CNT_W = (CLKS_PER_BAUD > 2) ? $clog2(CLKS_PER_BAUD) : 1;

    localparam int DATA_BITS = 8; // lsb goes out first

    // frame sequence, one state per bit field
    typedef enum logic [2:0] {
        ST_IDLE   = 3'd0,
        ST_START  = 3'd1,
        ST_DATA   = 3'd2,
        ST_PARITY = 3'd3,
        ST_STOP   = 3'd4
    } tx_state_t;

    // source of the serial line
    typedef enum logic [1:0] {
        LINE_MARK   = 2'd0, // idle and stop level
        LINE_START  = 2'd1, // start bit, low
        LINE_DATA   = 2'd2, // current shift bit
        LINE_PARITY = 2'd3  // accumulated even parity
    } line_sel_t;

    // controller to shifter
    typedef struct packed {
        logic      load;  // capture byte, clear parity
        logic      shift; // next data bit, fold into parity
        line_sel_t sel;
    } shift_cmd_t;

endpackage

//--- hdl/baud_timer.sv
module baud_timer
    import uart_pkg::*;
(
    input  logic clk,
    input  logic nRst,
    input  logic baud_run,
    output logic bit_done
);

    logic [BAUD_CNT_W-1:0] baud_cnt;
    logic                  at_last;

    assign at_last = (baud_cnt == BAUD_CNT_W'(CLKS_PER_BAUD - 1));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            baud_cnt <= '0;
        end else if (!baud_run) begin
            baud_cnt <= '0; // held while idle
        end else if (at_last) begin
            baud_cnt <= '0; // wrap into next bit
        end else begin
            baud_cnt <= baud_cnt + BAUD_CNT_W'(1);
        end
    end

    // the counter restarts at zero on every wrap, so all bits are equally long
    assign bit_done = at_last;

endmodule

//--- hdl/tx_shifter.sv
module tx_shifter
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    input  shift_cmd_t cmd,
    input  logic [7:0] tx_byte,
    output logic       tx_serial
);

    logic [DATA_BITS-1:0] shift_reg;
    logic [DATA_BITS-1:0] shift_next;
    logic                 parity;
    logic                 parity_next;
    logic                 line_next;

    always_comb begin
        shift_next  = shift_reg;
        parity_next = parity;
        if (cmd.load) begin
            shift_next  = tx_byte;
            parity_next = 1'b0;
        end else if (cmd.shift) begin
            parity_next = parity ^ shift_reg[0]; // outgoing bit
            shift_next  = {1'b0, shift_reg[DATA_BITS-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        shift_reg <= shift_next;
        parity    <= parity_next;
    end

    // pick from the next values so the line moves in step with sel and shift
    always_comb begin
        case (cmd.sel)
            LINE_START:  line_next = 1'b0;
            LINE_DATA:   line_next = shift_next[0];
            LINE_PARITY: line_next = parity_next; // includes last data bit
            default:     line_next = 1'b1;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            tx_serial <= 1'b1; // mark
        end else begin
            tx_serial <= line_next;
        end
    end

endmodule

//--- hdl/uart_tx_ctrl.sv
module uart_tx_ctrl
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_ctrl,
    input  logic       bit_done,
    output logic       transmit_ready,
    output logic       baud_run,
    output shift_cmd_t cmd
);

    tx_state_t  state;
    tx_state_t  state_next;
    logic [2:0] bit_idx;
    logic [2:0] bit_idx_next;
    logic       accept;
    logic       last_data;

    assign transmit_ready = (state == ST_IDLE);
    assign accept         = transmit_ready && tx_ctrl; // busy requests dropped
    assign baud_run       = (state != ST_IDLE);
    assign last_data      = (bit_idx == 3'(DATA_BITS - 1));

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state   <= ST_IDLE;
            bit_idx <= '0;
        end else begin
            state   <= state_next;
            bit_idx <= bit_idx_next;
        end
    end

    always_comb begin
        state_next   = state;
        bit_idx_next = bit_idx;
        case (state)
            ST_IDLE: begin
                bit_idx_next = '0;
                if (accept) begin
                    state_next = ST_START;
                end
            end
            ST_START: begin
                if (bit_done) begin
                    state_next = ST_DATA;
                end
            end
            ST_DATA: begin
                if (bit_done) begin
                    bit_idx_next = bit_idx + 3'd1; // wraps to 0 after bit 7
                    if (last_data) begin
                        state_next = ST_PARITY;
                    end
                end
            end
            ST_PARITY: begin
                if (bit_done) begin
                    state_next = ST_STOP;
                end
            end
            ST_STOP: begin
                if (bit_done) begin
                    state_next = ST_IDLE; // ready in the following cycle
                end
            end
            default: begin
                state_next   = ST_IDLE;
                bit_idx_next = '0;
            end
        endcase
    end

    // sel follows the state being entered; the shifter registers it, so the
    // line lags a state change by one cycle, same as acceptance to start bit
    always_comb begin
        cmd.load  = accept;
        cmd.shift = (state == ST_DATA) && bit_done;
        case (state_next)
            ST_START:  cmd.sel = LINE_START;
            ST_DATA:   cmd.sel = LINE_DATA;
            ST_PARITY: cmd.sel = LINE_PARITY;
            default:   cmd.sel = LINE_MARK; // idle and stop
        endcase
    end

endmodule

//--- hdl/uart_tx.sv
module uart_tx
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_ctrl,
    input  logic [7:0] tx_byte,
    output logic       transmit_ready,
    output logic       tx_serial
);

    logic       baud_run;
    logic       bit_done;
    shift_cmd_t cmd;

    uart_tx_ctrl u_ctrl (
        .clk            (clk),
        .nRst           (nRst),
        .tx_ctrl        (tx_ctrl),
        .bit_done       (bit_done),
        .transmit_ready (transmit_ready),
        .baud_run       (baud_run),
        .cmd            (cmd)
    );

    baud_timer u_timer (
        .clk      (clk),
        .nRst     (nRst),
        .baud_run (baud_run),
        .bit_done (bit_done)
    );

    // byte taken straight from the port, latched on load
    tx_shifter u_shifter (
        .clk       (clk),
        .nRst      (nRst),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .tx_serial (tx_serial)
    );

endmodule

//--- verification/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic nRst
);

    localparam time HALF_PERIOD = 50;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        nRst = 1'b0;
        repeat (2) @(posedge clk);
        #10 nRst = 1'b1; // released off the edge
    end

endmodule

//--- verification/uart_tx_checker.sv
module uart_tx_checker
    import uart_pkg::*;
(
    input  logic       clk,
    input  logic       nRst,
    input  logic       tx_ctrl,
    input  logic [7:0] tx_byte,
    input  logic       transmit_ready,
    input  logic       tx_serial,
    output int         error_count,
    output int         accept_count,
    output int         frame_count
);

    localparam int FRAME_CYCLES = 11 * CLKS_PER_BAUD; // start, 8 data, parity, stop
    localparam int MID_BIT      = CLKS_PER_BAUD / 2;

    logic       busy;
    logic       prev_ready;
    logic [7:0] exp_byte;
    int         cyc;
    int         bit_no;
    int         pos;

    task automatic flag_mismatch(input string name, input int expected, input int actual);
        error_count++;
        $display("CHECK FAILED %s: expected %0h actual %0h", name, expected, actual);
    endtask

    // high when the byte holds an odd number of ones
    function automatic logic parity_of(input logic [7:0] b);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += int'(b[i]);
        end
        return (ones % 2) == 1;
    endfunction

    // line level for bit field n of a frame, 0 is the start bit
    function automatic logic line_for_bit(input int n, input logic [7:0] b);
        if (n == 0) begin
            return 1'b0;
        end else if (n <= DATA_BITS) begin
            return b[n-1]; // lsb first
        end else if (n == DATA_BITS + 1) begin
            return parity_of(b);
        end
        return 1'b1;
    endfunction

    function automatic string field_name(input int n);
        if (n <= DATA_BITS) begin
            return $sformatf("data_bit_%0d", n - 1);
        end else if (n == DATA_BITS + 1) begin
            return "parity";
        end
        return "stop_bit";
    endfunction

    initial begin
        error_count  = 0;
        accept_count = 0;
        frame_count  = 0;
        busy         = 1'b0;
        prev_ready   = 1'b1;
        exp_byte     = 8'h00;
        cyc          = 0;
    end

    always @(posedge clk) begin
        if (!nRst) begin
            busy       = 1'b0;
            prev_ready = 1'b1;
        end else begin
            if (prev_ready && !transmit_ready) begin
                frame_count++; // one per frame the DUT starts
            end
            prev_ready = transmit_ready;

            if (busy) begin
                cyc++;
                bit_no = (cyc - 1) / CLKS_PER_BAUD;
                pos    = (cyc - 1) % CLKS_PER_BAUD;
                if (cyc <= FRAME_CYCLES) begin
                    if (transmit_ready !== 1'b0) begin
                        flag_mismatch("ready_busy", 0, int'(transmit_ready));
                    end
                    if (bit_no == 0) begin
                        if (tx_serial !== 1'b0) begin
                            flag_mismatch("start_bit", 0, int'(tx_serial));
                        end
                    end else if (pos == MID_BIT) begin
                        if (tx_serial !== line_for_bit(bit_no, exp_byte)) begin
                            flag_mismatch(field_name(bit_no),
                                          int'(line_for_bit(bit_no, exp_byte)),
                                          int'(tx_serial));
                        end
                    end
                end else begin
                    if (transmit_ready !== 1'b1) begin
                        flag_mismatch("ready_rise", 1, int'(transmit_ready));
                    end
                    busy = 1'b0; // a new frame may be accepted at this edge
                end
            end

            if (!busy) begin
                if (transmit_ready !== 1'b1) begin
                    flag_mismatch("ready_idle", 1, int'(transmit_ready));
                end
                if (tx_serial !== 1'b1) begin
                    flag_mismatch("idle_line", 1, int'(tx_serial));
                end
                if (tx_ctrl && transmit_ready) begin
                    accept_count++;
                    exp_byte = tx_byte;
                    busy     = 1'b1;
                    cyc      = 0;
                end
            end
        end
    end

endmodule

//--- verification/uart_tx_assertions.sv
module uart_tx_assertions
    import uart_pkg::*;
(
    input logic       clk,
    input logic       nRst,
    input logic       transmit_ready,
    input logic       tx_serial,
    input logic       baud_run,
    input logic       bit_done,
    input shift_cmd_t cmd,
    input tx_state_t  state
);

    int fail_count = 0;

    // line rests at mark whenever idle
    ready_line_mark: assert property (@(posedge clk) disable iff (!nRst)
        transmit_ready |-> tx_serial)
        else begin
            fail_count++;
            $error("tx_serial low while transmit_ready is high");
        end

    // a load comes from idle and puts the start bit on the line
    load_in_idle: assert property (@(posedge clk) disable iff (!nRst)
        cmd.load |=> ($past(state) == ST_IDLE) && (state == ST_START) && !tx_serial)
        else begin
            fail_count++;
            $error("shifter load outside ST_IDLE or not followed by a start bit");
        end

    done_needs_run: assert property (@(posedge clk) disable iff (!nRst)
        !baud_run |-> !bit_done)
        else begin
            fail_count++;
            $error("bit_done high while baud_run is low");
        end

endmodule

bind uart_tx uart_tx_assertions u_assertions (
    .clk            (clk),
    .nRst           (nRst),
    .transmit_ready (transmit_ready),
    .tx_serial      (tx_serial),
    .baud_run       (baud_run),
    .bit_done       (bit_done),
    .cmd            (cmd),
    .state          (u_ctrl.state)
);

//--- verification/uart_tx_tb.sv
module uart_tx_tb
    import uart_pkg::*;
();

    localparam int  NUM_FRAMES     = 40;
    localparam int  TIMEOUT_CYCLES = NUM_FRAMES * (11 * CLKS_PER_BAUD + 25) + 50;
    localparam time DRIVE_DELAY    = 10;

    logic       clk;
    logic       nRst;
    logic       tx_ctrl;
    logic [7:0] tx_byte;
    logic       transmit_ready;
    logic       tx_serial;
    int         error_count;
    int         accept_count;
    int         frame_count;
    int         count_errors;
    int         cycles;
    integer     seed;

    tb_clock u_clock (
        .clk  (clk),
        .nRst (nRst)
    );

    uart_tx u_uart_tx (
        .clk            (clk),
        .nRst           (nRst),
        .tx_ctrl        (tx_ctrl),
        .tx_byte        (tx_byte),
        .transmit_ready (transmit_ready),
        .tx_serial      (tx_serial)
    );

    uart_tx_checker u_checker (
        .clk            (clk),
        .nRst           (nRst),
        .tx_ctrl        (tx_ctrl),
        .tx_byte        (tx_byte),
        .transmit_ready (transmit_ready),
        .tx_serial      (tx_serial),
        .error_count    (error_count),
        .accept_count   (accept_count),
        .frame_count    (frame_count)
    );

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic compare_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            count_errors++;
            $display("CHECK FAILED %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // request one frame, then poke the busy DUT until it is ready again
    task automatic send_frame();
        logic was_ready;
        was_ready = 1'b0;
        tx_byte   = 8'($random(seed));
        tx_ctrl   = 1'b1;
        while (!was_ready) begin
            was_ready = transmit_ready; // stable until the next edge
            next_cycle();
        end
        tx_ctrl = 1'b0;
        while (!transmit_ready) begin
            tx_ctrl = (($random(seed) & 3) == 0); // ignored while busy
            tx_byte = 8'($random(seed));
            next_cycle();
        end
        tx_ctrl = 1'b0;
    endtask

    initial begin
        cycles = 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        int gap;
        int total;
        tx_ctrl      = 1'b0;
        tx_byte      = 8'h00;
        count_errors = 0;
        seed         = 32'h2950_fc4a;
        @(posedge nRst);
        next_cycle();
        compare_value("reset_ready", 1, int'(transmit_ready));
        compare_value("reset_line", 1, int'(tx_serial));

        for (int f = 0; f < NUM_FRAMES; f++) begin
            gap = int'($unsigned($random(seed)) % 21);
            repeat (gap) begin
                tx_byte = 8'($random(seed)); // not sampled while idle
                next_cycle();
            end
            send_frame();
        end
        repeat (4) next_cycle();

        compare_value("acceptances", NUM_FRAMES, accept_count);
        compare_value("frames_seen", NUM_FRAMES, frame_count);
        total = error_count + count_errors + u_uart_tx.u_assertions.fail_count;
        $display("errors: checker %0d, counts %0d, assertions %0d (frames %0d)",
                 error_count, count_errors, u_uart_tx.u_assertions.fail_count, frame_count);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- list.f
hdl/uart_pkg.sv
hdl/baud_timer.sv
hdl/tx_shifter.sv
hdl/uart_tx_ctrl.sv
hdl/uart_tx.sv
verification/tb_clock.sv
verification/uart_tx_checker.sv
verification/uart_tx_assertions.sv
verification/uart_tx_tb.sv

//--- run.sh
#!/bin/sh
# build the uart_tx testbench with Verilator, run it, judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module uart_tx_tb \
    -Mdir obj_dir -o uart_tx_sim > build.log 2>&1 \
    && ./obj_dir/uart_tx_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "FAIL: build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log || { echo "FAIL: no result in sim.log"; exit 1; }
echo "PASS"
exit 0
